// File: list.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/pipe_regs.sv
logic/run_control.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/exec_mem_stage.sv
logic/rv_core_top.sv
testbench/rv_core_properties.sv
testbench/rv_core_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := rv_core_tb
DUT_TOP    := rv_core_top
FILELIST   := list.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/core_patterns.txt
# L addr word: load one instruction word, S: start and wait for done
# R reg value: expected register after done; addr, word and value in hex, reg in decimal
L 00 00500093
L 01 00c00113
L 02 fff00193
L 03 40208233
L 04 001222b3
L 05 0020f333
L 06 0020e3b3
L 07 0020c433
L 08 00f1c493
L 09 00617513
L 0a 0300e593
L 0b 0000006f
S
R 1 00000005
R 2 0000000c
R 3 ffffffff
R 4 fffffff9
R 5 00000001
R 6 00000004
R 7 0000000d
R 8 00000009
R 9 fffffff0
R 10 00000004
R 11 00000035
R 12 00000000
L 00 00700093
L 01 00108133
L 02 0020a1b3
L 03 00314233
L 04 00402423
L 05 00802283
L 06 00328013
L 07 00028333
L 08 0000006f
S
R 0 00000000
R 1 00000007
R 2 0000000e
R 3 00000001
R 4 0000000f
R 5 0000000f
R 6 0000000f
R 11 00000035

// File: testbench/rv_core_tb.sv
module rv_core_tb
    import core_pkg::*;
();

    localparam int DONE_TIMEOUT = 500;
    localparam int MAX_RECORDS  = 1000;

    logic               clk;
    logic               i_arst_n;
    logic               i_load;
    logic [IADDR_W-1:0] i_load_addr;
    logic [XLEN-1:0]    i_load_word;
    logic               i_start;
    logic               o_done;
    logic [4:0]         i_dbg_sel;
    logic [XLEN-1:0]    o_dbg_data;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_errors = 0;
    int    test_checks = 0;
    bit    test_open = 1'b0;
    bit    started = 1'b0;
    bit    stop = 1'b0;
    string test_name;
    int    prog_num = 0;
    int    done_count = 0;
    int    done_mark = 0;

    int                 fd;
    int                 code;
    int                 records = 0;
    logic               got_done = 1'b0;
    logic [7:0]         kind;
    logic [8*128-1:0]   line_buf;
    logic [IADDR_W-1:0] rec_addr;
    logic [XLEN-1:0]    rec_word;
    logic [4:0]         rec_sel;

    rv_core_top rv_core_top_inst (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_load      (i_load),
        .i_load_addr (i_load_addr),
        .i_load_word (i_load_word),
        .i_start     (i_start),
        .o_done      (o_done),
        .i_dbg_sel   (i_dbg_sel),
        .o_dbg_data  (o_dbg_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Every done strobe over the whole run
    always @(negedge clk)
    begin
        if (o_done)
            done_count++;
    end

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
        test_open   = 1'b1;
        started     = 1'b0;
    endtask

    task automatic close_test();
        if (test_open)
        begin
            tests_run++;
            if (test_errors == 0)
                $display("%s: ok, %0d checks", test_name, test_checks);
            else
            begin
                tests_failed++;
                $display("%s: %0d of %0d checks wrong", test_name, test_errors, test_checks);
            end
            test_open = 1'b0;
        end
    endtask

    task automatic check_reg(input logic [4:0] sel, input logic [XLEN-1:0] expected);
        @(posedge clk);
        i_dbg_sel <= sel;
        @(negedge clk);
        test_checks++;
        if (o_dbg_data !== expected)
        begin
            $display("[ERROR] %0t: x%0d reads %h, expected %h", $time, sel, o_dbg_data, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_done_pulses(input int count, input int expected);
        test_checks++;
        if (count != expected)
        begin
            $display("[ERROR] %0t: %0d done strobes, expected %0d", $time, count, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic load_word(input logic [IADDR_W-1:0] addr, input logic [XLEN-1:0] word);
        @(posedge clk);
        i_load      <= 1'b1;
        i_load_addr <= addr;
        i_load_word <= word;
        @(posedge clk);
        i_load <= 1'b0;
    endtask

    task automatic wait_done(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT)
        begin
            @(negedge clk);
            if (o_done)
                seen = 1'b1;
            cycles++;
        end
    endtask

    task automatic run_program();
        if (!test_open)
        begin
            prog_num++;
            open_test($sformatf("program %0d", prog_num));
        end
        // Nothing may signal done while the program is only being loaded
        check_done_pulses(done_count - done_mark, 0);
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        wait_done(got_done);
        started = 1'b1;
        if (!got_done)
        begin
            $display("%s: no done strobe within %0d cycles of start", test_name, DONE_TIMEOUT);
            errors++;
            test_errors++;
            stop = 1'b1;
        end
    endtask

    task automatic close_program();
        // Short window to catch a late second strobe
        repeat (4) @(posedge clk);
        check_done_pulses(done_count - done_mark, 1);
        done_mark = done_count;
        close_test();
    endtask

    initial
    begin
        i_arst_n    = 1'b0;
        i_load      = 1'b0;
        i_load_addr = '0;
        i_load_word = '0;
        i_start     = 1'b0;
        i_dbg_sel   = '0;
        repeat (3) @(posedge clk);
        i_arst_n <= 1'b1;
        @(posedge clk);

        open_test("reset");
        for (int r = 0; r < 32; r++)
            check_reg(5'(r), '0);
        check_done_pulses(done_count - done_mark, 0);
        close_test();

        fd = $fopen("testbench/core_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open testbench/core_patterns.txt");
            errors++;
        end
        else
        begin
            while (!stop && records < MAX_RECORDS)
            begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1)
                    stop = 1'b1;
                else
                begin
                    records++;
                    case (kind)
                        "#":
                            code = $fgets(line_buf, fd);
                        "L":
                        begin
                            code = $fscanf(fd, "%h %h", rec_addr, rec_word);
                            if (test_open && started)
                                close_program();
                            if (!test_open)
                            begin
                                prog_num++;
                                open_test($sformatf("program %0d", prog_num));
                            end
                            if (code == 2)
                                load_word(rec_addr, rec_word);
                            else
                            begin
                                $display("Malformed load record in the pattern file");
                                errors++;
                                stop = 1'b1;
                            end
                        end
                        "S":
                            run_program();
                        "R":
                        begin
                            code = $fscanf(fd, "%d %h", rec_sel, rec_word);
                            if (code == 2)
                                check_reg(rec_sel, rec_word);
                            else
                            begin
                                $display("Malformed register record in the pattern file");
                                errors++;
                                stop = 1'b1;
                            end
                        end
                        default:
                        begin
                            $display("Unknown record '%c' in the pattern file", kind);
                            errors++;
                            stop = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (test_open && started && got_done)
                close_program();
            else
                close_test();
            if (prog_num == 0)
            begin
                $display("The pattern file holds no program");
                errors++;
            end
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: testbench/rv_core_properties.sv
module rv_core_properties
    import core_pkg::*;
(
    input logic            clk,
    input logic            i_arst_n,
    input logic            i_start,
    input logic            i_done,
    input logic [4:0]      i_dbg_sel,
    input logic [XLEN-1:0] i_dbg_data,
    input logic [4:0]      i_rs1_sel,
    input logic [XLEN-1:0] i_rs1_data
);

    // Set by a start, cleared by the done that ends that run
    logic armed;

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            armed <= 1'b0;
        else if (i_start)
            armed <= 1'b1;
        else if (i_done)
            armed <= 1'b0;
    end

    done_single_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_done |=> !i_done)
        else $error("o_done held high for two cycles");

    done_needs_start: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_done |-> armed)
        else $error("o_done without a start since the previous o_done");

    x0_debug_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_dbg_sel == 5'd0) |-> (i_dbg_data == '0))
        else $error("x0 reads nonzero on the debug port");

    x0_operand_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_rs1_sel == 5'd0) |-> (i_rs1_data == '0))
        else $error("x0 reads nonzero on the rs1 port");

endmodule

bind rv_core_top rv_core_properties rv_core_properties_inst (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_start    (i_start),
    .i_done     (o_done),
    .i_dbg_sel  (i_dbg_sel),
    .i_dbg_data (o_dbg_data),
    .i_rs1_sel  (rs1_sel),
    .i_rs1_data (rs1_data)
);

// File: logic/rv_core_top.sv
module rv_core_top
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_load,
    input  logic [IADDR_W-1:0] i_load_addr,
    input  logic [XLEN-1:0]    i_load_word,
    input  logic               i_start,
    output logic               o_done,
    input  logic [4:0]         i_dbg_sel,
    output logic [XLEN-1:0]    o_dbg_data
);

    logic            fetch_en;
    logic            restart;
    logic            stall;
    logic            halt_seen;
    logic [4:0]      rs1_sel;
    logic [4:0]      rs2_sel;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    if_id_t          fd_d;
    if_id_t          fd_q;
    id_ex_t          de_d;
    id_ex_t          de_q;
    ex_mem_t         em_d;
    ex_mem_t         em_q;
    mem_wb_t         wb_d;
    mem_wb_t         wb_q;

    run_control run_control_inst (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_start     (i_start),
        .i_halt_seen (halt_seen),
        .o_fetch_en  (fetch_en),
        .o_restart   (restart),
        .o_done      (o_done)
    );

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_load      (i_load),
        .i_load_addr (i_load_addr),
        .i_load_word (i_load_word),
        .i_fetch_en  (fetch_en),
        .i_restart   (restart),
        .i_stall     (stall),
        .o_fetch     (fd_d)
    );

    if_id if_id_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_stall  (stall),
        .i_d      (fd_d),
        .o_q      (fd_q)
    );

    decode_stage decode_stage_inst (
        .i_fd        (fd_q),
        .i_rs1_data  (rs1_data),
        .i_rs2_data  (rs2_data),
        .i_ex_rd     (de_q.rd),
        .i_ex_wr     (de_q.ctrl.reg_write),
        .i_mem_rd    (em_q.rd),
        .i_mem_wr    (em_q.ctrl.reg_write),
        .o_rs1_sel   (rs1_sel),
        .o_rs2_sel   (rs2_sel),
        .o_de        (de_d),
        .o_stall     (stall),
        .o_halt_seen (halt_seen)
    );

    reg_file reg_file_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_rs1_sel  (rs1_sel),
        .i_rs2_sel  (rs2_sel),
        .i_dbg_sel  (i_dbg_sel),
        .i_wb       (wb_q),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_dbg_data (o_dbg_data)
    );

    id_ex id_ex_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_bubble (stall),
        .i_d      (de_d),
        .o_q      (de_q)
    );

    exec_mem_stage exec_mem_stage_inst (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_de      (de_q),
        .i_em      (em_q),
        .o_em_next (em_d),
        .o_wb_next (wb_d)
    );

    ex_mem ex_mem_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_d      (em_d),
        .o_q      (em_q)
    );

    mem_wb mem_wb_inst (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_d      (wb_d),
        .o_q      (wb_q)
    );

endmodule

// File: logic/exec_mem_stage.sv
module exec_mem_stage
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    i_arst_n,
    input  id_ex_t  i_de,
    input  ex_mem_t i_em,
    output ex_mem_t o_em_next,
    output mem_wb_t o_wb_next
);

    logic [XLEN-1:0]    operand_b;
    logic [XLEN-1:0]    alu_result;
    logic [XLEN-1:0]    dmem [DMEM_DEPTH];
    logic [DADDR_W-1:0] dmem_addr;

    assign operand_b = i_de.ctrl.alu_src ? i_de.imm : i_de.rs2_data;

    always_comb
    begin
        case (i_de.alu_op)
            ALU_ADD: alu_result = i_de.rs1_data + operand_b;
            ALU_SUB: alu_result = i_de.rs1_data - operand_b;
            ALU_AND: alu_result = i_de.rs1_data & operand_b;
            ALU_OR:  alu_result = i_de.rs1_data | operand_b;
            ALU_XOR: alu_result = i_de.rs1_data ^ operand_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}},
                                   $signed(i_de.rs1_data) < $signed(operand_b)};
            default: alu_result = '0;
        endcase
    end

    assign o_em_next = '{alu_result: alu_result, store_data: i_de.rs2_data,
                         rd: i_de.rd, ctrl: i_de.ctrl};

    // Word index taken from the ALU byte address
    assign dmem_addr = i_em.alu_result[DADDR_W+1:2];

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end
        else if (i_em.ctrl.valid && i_em.ctrl.mem_write)
        begin
            dmem[dmem_addr] <= i_em.store_data;
        end
    end

    assign o_wb_next.wb_data   = i_em.ctrl.mem_to_reg ? dmem[dmem_addr] : i_em.alu_result;
    assign o_wb_next.rd        = i_em.rd;
    assign o_wb_next.reg_write = i_em.ctrl.reg_write;

endmodule

// File: logic/reg_file.sv
module reg_file
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic [4:0]      i_rs1_sel,
    input  logic [4:0]      i_rs2_sel,
    input  logic [4:0]      i_dbg_sel,
    input  mem_wb_t         i_wb,
    output logic [XLEN-1:0] o_rs1_data,
    output logic [XLEN-1:0] o_rs2_data,
    output logic [XLEN-1:0] o_dbg_data
);

    logic [XLEN-1:0] regs [32];
    logic            wb_en;

    // x0 is never written so it stays at its reset value
    assign wb_en = i_wb.reg_write && (i_wb.rd != 5'd0);

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_en)
        begin
            regs[i_wb.rd] <= i_wb.wb_data;
        end
    end

    // Write-first
    assign o_rs1_data = (wb_en && i_wb.rd == i_rs1_sel) ? i_wb.wb_data : regs[i_rs1_sel];
    assign o_rs2_data = (wb_en && i_wb.rd == i_rs2_sel) ? i_wb.wb_data : regs[i_rs2_sel];
    assign o_dbg_data = regs[i_dbg_sel];

endmodule

// File: logic/decode_stage.sv
module decode_stage
    import isa_pkg::*;
    import core_pkg::*;
(
    input  if_id_t          i_fd,
    input  logic [XLEN-1:0] i_rs1_data,
    input  logic [XLEN-1:0] i_rs2_data,
    input  logic [4:0]      i_ex_rd,
    input  logic            i_ex_wr,
    input  logic [4:0]      i_mem_rd,
    input  logic            i_mem_wr,
    output logic [4:0]      o_rs1_sel,
    output logic [4:0]      o_rs2_sel,
    output id_ex_t          o_de,
    output logic            o_stall,
    output logic            o_halt_seen
);

    instr_u          ins;
    ctrl_t           ctrl;
    alu_op_e         alu_op;
    logic [XLEN-1:0] imm;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            rs1_hit;
    logic            rs2_hit;

    assign ins       = i_fd.instr;
    assign o_rs1_sel = ins.r.rs1;
    assign o_rs2_sel = ins.r.rs2;

    always_comb
    begin
        ctrl     = '0;
        alu_op   = ALU_ADD;
        imm      = {{20{ins.i.imm[11]}}, ins.i.imm};
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (ins.r.opcode)
            OP_R:
            begin
                ctrl     = '{valid: 1'b1, reg_write: 1'b1, default: 1'b0};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                case ({ins.r.funct7, ins.r.funct3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:  alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}: alu_op = ALU_SLT;
                    default:           ctrl = '0;
                endcase
            end
            OP_IMM:
            begin
                ctrl     = '{valid: 1'b1, reg_write: 1'b1, alu_src: 1'b1, default: 1'b0};
                uses_rs1 = 1'b1;
                case (ins.i.funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_AND:  alu_op = ALU_AND;
                    F3_OR:   alu_op = ALU_OR;
                    F3_XOR:  alu_op = ALU_XOR;
                    default: ctrl = '0;
                endcase
            end
            OP_LOAD:
            begin
                uses_rs1 = 1'b1;
                if (ins.i.funct3 == F3_WORD)
                    ctrl = '{valid: 1'b1, reg_write: 1'b1, mem_to_reg: 1'b1,
                             alu_src: 1'b1, default: 1'b0};
            end
            OP_STORE:
            begin
                imm      = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                if (ins.s.funct3 == F3_WORD)
                    ctrl = '{valid: 1'b1, mem_write: 1'b1, alu_src: 1'b1, default: 1'b0};
            end
            // Halt and anything unknown pass on as a bubble
            default:
                ctrl = '0;
        endcase
    end

    // No forwarding, so wait until the producer reaches write-back
    assign rs1_hit = uses_rs1 && (ins.r.rs1 != 5'd0)
                     && ((i_ex_wr && ins.r.rs1 == i_ex_rd) || (i_mem_wr && ins.r.rs1 == i_mem_rd));
    assign rs2_hit = uses_rs2 && (ins.r.rs2 != 5'd0)
                     && ((i_ex_wr && ins.r.rs2 == i_ex_rd) || (i_mem_wr && ins.r.rs2 == i_mem_rd));
    assign o_stall = ctrl.valid && (rs1_hit || rs2_hit);

    assign o_halt_seen = (i_fd.instr == HALT_WORD);

    assign o_de = '{rs1_data: i_rs1_data, rs2_data: i_rs2_data, imm: imm,
                    alu_op: alu_op, rd: ins.r.rd, ctrl: ctrl};

endmodule

// File: logic/fetch_unit.sv
module fetch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               i_arst_n,
    input  logic               i_load,
    input  logic [IADDR_W-1:0] i_load_addr,
    input  logic [XLEN-1:0]    i_load_word,
    input  logic               i_fetch_en,
    input  logic               i_restart,
    input  logic               i_stall,
    output if_id_t             o_fetch
);

    logic [XLEN-1:0]    imem [IMEM_DEPTH];
    logic [IADDR_W-1:0] pc;

    // Program load only while the core is not fetching
    always_ff @(posedge clk)
    begin
        if (i_load && !i_fetch_en)
            imem[i_load_addr] <= i_load_word;
    end

    // Word address that wraps at the end of the memory
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            pc <= '0;
        else if (i_restart)
            pc <= '0;
        else if (i_fetch_en && !i_stall)
            pc <= pc + 1'b1;
    end

    assign o_fetch.instr = i_fetch_en ? imem[pc] : NOP_WORD;
    assign o_fetch.pc    = pc;

endmodule

// File: logic/run_control.sv
module run_control
    import core_pkg::*;
(
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_start,
    input  logic i_halt_seen,
    output logic o_fetch_en,
    output logic o_restart,
    output logic o_done
);

    run_state_e             state;
    logic [DRAIN_CNT_W-1:0] drain_cnt;
    logic                   drain_last;

    assign drain_last = (drain_cnt == DRAIN_CNT_W'(DRAIN_CYCLES - 1));

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state     <= IDLE;
            drain_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (i_start)
                        state <= RUN;
                RUN:
                    if (i_halt_seen)
                    begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                DRAIN:
                    if (drain_last)
                        state <= IDLE;
                    else
                        drain_cnt <= drain_cnt + 1'b1;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Fetch stops in the halt cycle so the word behind the halt never enters decode
    assign o_fetch_en = (state == RUN) && !i_halt_seen;
    assign o_restart  = (state == IDLE) && i_start;
    assign o_done     = (state == DRAIN) && drain_last;

endmodule

// File: logic/pipe_regs.sv
module if_id
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   i_arst_n,
    input  logic   i_stall,
    input  if_id_t i_d,
    output if_id_t o_q
);

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_q.instr <= NOP_WORD;
            o_q.pc    <= '0;
        end
        else if (!i_stall)
        begin
            o_q <= i_d;
        end
    end

endmodule

module id_ex
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   i_arst_n,
    input  logic   i_bubble,
    input  id_ex_t i_d,
    output id_ex_t o_q
);

    // A bubble carries an all-zero ctrl, so nothing downstream acts on it
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_q <= '0;
        else if (i_bubble)
            o_q <= '0;
        else
            o_q <= i_d;
    end

endmodule

module ex_mem
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    i_arst_n,
    input  ex_mem_t i_d,
    output ex_mem_t o_q
);

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_q <= '0;
        else
            o_q <= i_d;
    end

endmodule

module mem_wb
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    i_arst_n,
    input  mem_wb_t i_d,
    output mem_wb_t o_q
);

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_q <= '0;
        else
            o_q <= i_d;
    end

endmodule

// File: logic/core_pkg.sv
package core_pkg;

    import isa_pkg::*;

    localparam int XLEN         = 32;
    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int IADDR_W      = 6;
    localparam int DADDR_W      = $clog2(DMEM_DEPTH);
    localparam int DRAIN_CYCLES = 4;
    localparam int DRAIN_CNT_W  = $clog2(DRAIN_CYCLES);

    typedef struct packed
    {
        instr_u               instr;
        logic [IADDR_W-1:0]   pc;
    } if_id_t;

    typedef struct packed
    {
        logic valid;
        logic reg_write;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src;
    } ctrl_t;

    typedef struct packed
    {
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        alu_op_e         alu_op;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } id_ex_t;

    typedef struct packed
    {
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed
    {
        logic [XLEN-1:0] wb_data;
        logic [4:0]      rd;
        logic            reg_write;
    } mem_wb_t;

    typedef enum logic [1:0]
    {
        IDLE,
        RUN,
        DRAIN
    } run_state_e;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

    typedef enum logic [6:0]
    {
        OP_R     = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011,
        OP_JAL   = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    // jal x0, 0 marks the end of a program
    localparam logic [31:0] HALT_WORD = 32'h0000_006f;

    typedef struct packed
    {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed
    {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed
    {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed
    {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_u;

endpackage
